// File: tb.f
hw/acc_pkg.sv
hw/item_core.sv
hw/core_array.sv
hw/cmd_fifo.sv
hw/array_sequencer.sv
hw/accel_top.sv
bench/accel_checker.sv
bench/accel_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module accel_tb \
    -f tb.f --Mdir obj_dir -o accel_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/accel_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
exit 1

// File: bench/accel_tb.sv
`timescale 1ns/100ps

module accel_tb;

    localparam int NUM_CORES      = 8;
    localparam int FIFO_DEPTH     = 4;
    localparam int RES_CREDITS    = 2;
    localparam int WORDS_USED     = 16;    // item indices the tests touch.
    localparam int TIMEOUT_CYCLES = 20000; // longest test runs well under 2000.

    logic             clk;
    logic             reset;
    logic             cmd_valid;
    acc_pkg::cmd_t    cmd;
    logic             cmd_credit;
    logic             res_valid;
    acc_pkg::result_t res;
    logic             res_credit;

    logic [31:0]      model_mem [NUM_CORES][2**acc_pkg::ITEM_AW];
    logic [31:0]      model_sum [NUM_CORES];
    acc_pkg::result_t got_q [$];
    integer           seed;
    int               host_credits;
    int               cmds_sent;
    int               credits_back;
    int               owed;
    int               outstanding;
    bit               hold_credits;
    int               errors;
    int               err_mark;
    int               checks;
    int               tests;
    int               cycles;

    accel_top #(
        .NUM_CORES   (NUM_CORES),
        .FIFO_DEPTH  (FIFO_DEPTH),
        .RES_CREDITS (RES_CREDITS)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .res_valid  (res_valid),
        .res        (res),
        .res_credit (res_credit)
    );

    bind array_sequencer accel_checker #(.NUM_CORES(NUM_CORES), .RES_CREDITS(RES_CREDITS)) u_checker (
        .clk        (clk),
        .reset      (reset),
        .init       (init),
        .exec       (exec),
        .update     (update),
        .shift      (shift),
        .res_valid  (res_valid),
        .res_credit (res_credit)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("SIMULATION FAILED");
        $finish;
    end

    // ************************************************************
    // host credits and result sink
    // ************************************************************

    always @(negedge clk) begin
        if (!reset && cmd_credit) begin
            host_credits++;
            credits_back++;
        end
        if (!reset && res_valid) begin
            got_q.push_back(res);
            owed++;
            outstanding++;
            if (outstanding > RES_CREDITS) begin
                $display("sink holds %0d results against %0d credits", outstanding, RES_CREDITS);
                errors++;
            end
        end
    end

    initial begin
        forever begin
            @(posedge clk);
            if (res_credit) begin
                outstanding--; // DUT takes the credit back at this edge.
            end
            #2;
            res_credit = 1'b0;
            if (owed > 0 && !(hold_credits && (($random(seed) & 3) != 0))) begin
                res_credit = 1'b1;
                owed--;
            end
        end
    end

    // ************************************************************
    // driver, model and checks
    // ************************************************************

    task automatic send_cmd(input acc_pkg::opcode_t op, input int core, input int addr,
                            input logic [31:0] data);
        while (host_credits == 0) begin
            @(posedge clk);
            #2;
        end
        cmd_valid = 1'b1;
        cmd = '{op: op, core: acc_pkg::CORE_W'(core), addr: acc_pkg::ITEM_AW'(addr), data: data};
        host_credits--;
        cmds_sent++;
        @(posedge clk);
        #2;
        cmd_valid = 1'b0;
    endtask

    task automatic load_word(input int core, input int addr, input logic [31:0] data);
        model_mem[core][addr] = data;
        send_cmd(acc_pkg::OP_LOAD, core, addr, data);
    endtask

    task automatic run_exec(input int addr);
        int c;
        for (c = 0; c < NUM_CORES; c++) begin
            model_sum[c] += model_mem[c][addr]; // wraps modulo 2^32.
        end
        send_cmd(acc_pkg::OP_EXEC, 0, addr, 32'h0);
    endtask

    task automatic clear_sums();
        int c;
        for (c = 0; c < NUM_CORES; c++) begin
            model_sum[c] = 32'h0;
        end
        send_cmd(acc_pkg::OP_INIT, 0, 0, 32'h0);
    endtask

    function automatic int pick_index();
        int r;
        r = $random(seed);
        return r & (WORDS_USED - 1);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic drain_and_check(input string name);
        acc_pkg::result_t r;
        int c;
        send_cmd(acc_pkg::OP_DRAIN, 0, 0, 32'h0);
        while (got_q.size() < NUM_CORES) begin
            @(posedge clk);
            #2;
        end
        for (c = 0; c < NUM_CORES; c++) begin
            r = got_q.pop_front();
            check_value({name, " core"}, 32'(c), 32'(r.core));
            check_value({name, " sum"}, model_sum[c], r.sum);
            check_value({name, " last"}, 32'(c == NUM_CORES - 1), 32'(r.last));
        end
    endtask

    task automatic finish_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    // ************************************************************
    // directed tests
    // ************************************************************

    task automatic single_drain();
        int c;
        for (c = 0; c < NUM_CORES; c++) begin
            load_word(c, 5, 32'h100 * 32'(c + 1) + 32'(c));
        end
        clear_sums();
        run_exec(5);
        drain_and_check("single_drain");
        finish_test("single_drain");
    endtask

    task automatic exec_burst();
        int a;
        int c;
        int i;
        for (a = 0; a < WORDS_USED; a++) begin
            for (c = 0; c < NUM_CORES; c++) begin
                load_word(c, a, $random(seed));
            end
        end
        clear_sums();
        for (i = 0; i < 12; i++) begin
            run_exec(pick_index()); // back to back, several in flight.
        end
        drain_and_check("exec_burst");
        finish_test("exec_burst");
    endtask

    task automatic init_clears();
        int i;
        clear_sums();
        for (i = 0; i < 4; i++) begin
            run_exec(pick_index());
        end
        clear_sums();
        for (i = 0; i < 3; i++) begin
            run_exec(pick_index());
        end
        drain_and_check("init_clears");
        finish_test("init_clears");
    endtask

    task automatic result_backpressure();
        int i;
        clear_sums();
        for (i = 0; i < 3; i++) begin
            run_exec(pick_index());
        end
        hold_credits = 1'b1;
        drain_and_check("result_backpressure");
        hold_credits = 1'b0;
        finish_test("result_backpressure");
    endtask

    task automatic command_credits();
        int i;
        int sent0;
        int back0;
        int guard;
        sent0 = cmds_sent;
        back0 = credits_back;
        clear_sums();
        for (i = 0; i < 40; i++) begin
            if (i % 4 == 3) begin
                run_exec(pick_index());
            end else begin
                load_word(i % NUM_CORES, pick_index(), $random(seed));
            end
        end
        drain_and_check("command_credits");
        guard = 0;
        while (host_credits != FIFO_DEPTH && guard < 100) begin
            @(posedge clk);
            #2;
            guard++;
        end
        if (host_credits != FIFO_DEPTH) begin
            $display("command_credits: host holds %0d credits once idle, not %0d",
                     host_credits, FIFO_DEPTH);
            errors++;
        end
        check_value("command_credits returned", 32'(cmds_sent - sent0),
                    32'(credits_back - back0));
        finish_test("command_credits");
    endtask

    initial begin
        seed         = 32'h92dc;
        reset        = 1'b1;
        cmd_valid    = 1'b0;
        cmd          = '0;
        res_credit   = 1'b0;
        host_credits = FIFO_DEPTH;
        hold_credits = 1'b0;
        errors       = 0;
        err_mark     = 0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        single_drain();
        exec_burst();
        init_clears();
        result_backpressure();
        command_credits();
        repeat (4) @(posedge clk);
        if (got_q.size() != 0) begin
            $display("%0d results arrived with no drain pending", got_q.size());
            errors++;
        end
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: bench/accel_checker.sv
`timescale 1ns/100ps

module accel_checker #(
    parameter int NUM_CORES   = 8,
    parameter int RES_CREDITS = 2
) (
    input logic clk,
    input logic reset,
    input logic init,
    input logic exec,
    input logic update,
    input logic shift,
    input logic res_valid,
    input logic res_credit
);

    localparam int CW = $clog2(RES_CREDITS + 1);
    localparam int IW = $clog2(NUM_CORES + 1);

    logic [CW-1:0] credits_held; // credits as the sink sees them.
    logic [IW-1:0] shifts_left;  // chain values still to leave.

    always_ff @(posedge clk) begin
        if (reset) begin
            credits_held <= CW'(RES_CREDITS);
            shifts_left  <= '0;
        end else begin
            credits_held <= credits_held + CW'(res_credit) - CW'(res_valid);
            if (update) begin
                shifts_left <= IW'(NUM_CORES - 1);
            end else if (shift && (shifts_left != '0)) begin
                shifts_left <= shifts_left - 1'b1;
            end
        end
    end

    res_needs_credit: assert property (@(posedge clk) disable iff (reset)
        res_valid |-> (credits_held != '0))
        else $error("result sent while no result credit was held");

    update_with_shift: assert property (@(posedge clk) disable iff (reset)
        update |-> (shift && (shifts_left == '0)))
        else $error("chain update raised without shift or before the last value left");

    shift_within_drain: assert property (@(posedge clk) disable iff (reset)
        (shift && !update) |-> (shifts_left != '0))
        else $error("chain shifted past the last core");

    // the clear lands two edges after init, so exec holds off four cycles.
    exec_after_init: assert property (@(posedge clk) disable iff (reset)
        exec |-> !($past(init, 1) || $past(init, 2) || $past(init, 3) || $past(init, 4)))
        else $error("exec issued within four cycles of init");

endmodule

// File: hw/accel_top.sv
`timescale 1ns/100ps

module accel_top #(
    parameter int NUM_CORES   = 8,
    parameter int FIFO_DEPTH  = 4,
    parameter int RES_CREDITS = 2
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             cmd_valid,
    input  acc_pkg::cmd_t    cmd,
    output logic             cmd_credit,
    output logic             res_valid,
    output acc_pkg::result_t res,
    input  logic             res_credit
);

    acc_pkg::cmd_t               fifo_cmd;
    logic                        fifo_valid;
    logic                        fifo_pop;
    logic                        init;
    acc_pkg::load_t              load;
    logic                        exec;
    logic [acc_pkg::ITEM_AW-1:0] exec_addr;
    logic                        update;
    logic                        shift;
    logic [31:0]                 chain_out;

    cmd_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .fifo_valid (fifo_valid),
        .fifo_cmd   (fifo_cmd),
        .fifo_pop   (fifo_pop),
        .cmd_credit (cmd_credit)
    );

    array_sequencer #(
        .NUM_CORES   (NUM_CORES),
        .RES_CREDITS (RES_CREDITS)
    ) u_seq (
        .clk        (clk),
        .reset      (reset),
        .fifo_valid (fifo_valid),
        .fifo_cmd   (fifo_cmd),
        .fifo_pop   (fifo_pop),
        .init       (init),
        .load       (load),
        .exec       (exec),
        .exec_addr  (exec_addr),
        .update     (update),
        .shift      (shift),
        .chain_out  (chain_out),
        .res_valid  (res_valid),
        .res        (res),
        .res_credit (res_credit)
    );

    core_array #(
        .NUM_CORES (NUM_CORES)
    ) u_array (
        .clk       (clk),
        .init      (init),
        .load      (load),
        .exec      (exec),
        .exec_addr (exec_addr),
        .update    (update),
        .shift     (shift),
        .chain_out (chain_out)
    );

endmodule

// File: hw/array_sequencer.sv
`timescale 1ns/100ps

module array_sequencer #(
    parameter int NUM_CORES   = 8,
    parameter int RES_CREDITS = 2
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        fifo_valid,
    input  acc_pkg::cmd_t               fifo_cmd,
    output logic                        fifo_pop,
    output logic                        init,
    output acc_pkg::load_t              load,
    output logic                        exec,
    output logic [acc_pkg::ITEM_AW-1:0] exec_addr,
    output logic                        update,
    output logic                        shift,
    input  logic [31:0]                 chain_out,
    output logic                        res_valid,
    output acc_pkg::result_t            res,
    input  logic                        res_credit
);

    localparam int         CW          = $clog2(RES_CREDITS + 1);
    localparam logic [2:0] BUSY_CYCLES = 3'd4;

    acc_pkg::opcode_t            op;
    logic                        issue_ok;
    logic                        send;
    logic                        last_out;
    logic                        draining;
    logic                        first_q;
    logic [acc_pkg::CORE_W-1:0]  drain_idx;
    logic [2:0]                  busy_cnt;
    logic                        init_hold;
    logic [CW-1:0]               res_credits;

    // ************************************************************
    // command issue
    // ************************************************************

    assign op = fifo_cmd.op;

    always_comb begin
        case (op)
            acc_pkg::OP_EXEC:  issue_ok = !init_hold;         // wait for the clear.
            acc_pkg::OP_DRAIN: issue_ok = (busy_cnt == 3'd0); // pipeline settled.
            default:           issue_ok = 1'b1;
        endcase
    end

    assign fifo_pop  = fifo_valid && !draining && issue_ok;
    assign init      = fifo_pop && (op == acc_pkg::OP_INIT);
    assign exec      = fifo_pop && (op == acc_pkg::OP_EXEC);
    assign exec_addr = fifo_cmd.addr;
    assign load.we   = fifo_pop && (op == acc_pkg::OP_LOAD);
    assign load.core = fifo_cmd.core;
    assign load.addr = fifo_cmd.addr;
    assign load.data = fifo_cmd.data;

    // ************************************************************
    // drain output
    // ************************************************************

    assign send      = draining && (res_credits != '0);
    assign last_out  = (drain_idx == acc_pkg::CORE_W'(NUM_CORES - 1));
    assign update    = send && first_q; // parallel load into the chain.
    assign shift     = send;
    assign res_valid = send;
    assign res.last  = last_out;
    assign res.core  = drain_idx;
    assign res.sum   = chain_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            draining    <= 1'b0;
            first_q     <= 1'b0;
            drain_idx   <= '0;
            busy_cnt    <= 3'd0;
            init_hold   <= 1'b0;
            res_credits <= CW'(RES_CREDITS);
        end else begin
            if (init || exec) begin
                busy_cnt <= BUSY_CYCLES;
            end else if (busy_cnt != 3'd0) begin
                busy_cnt <= busy_cnt - 3'd1;
            end

            if (init) begin
                init_hold <= 1'b1;
            end else if (busy_cnt <= 3'd1) begin
                init_hold <= 1'b0;
            end

            res_credits <= res_credits + CW'(res_credit) - CW'(send);

            if (fifo_pop && (op == acc_pkg::OP_DRAIN)) begin
                draining  <= 1'b1;
                first_q   <= 1'b1;
                drain_idx <= '0;
            end else if (send) begin
                first_q <= 1'b0;
                if (last_out) begin
                    draining <= 1'b0;
                end else begin
                    drain_idx <= drain_idx + 1'b1;
                end
            end
        end
    end

endmodule

// File: hw/cmd_fifo.sv
`timescale 1ns/100ps

module cmd_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          cmd_valid,
    input  acc_pkg::cmd_t cmd,
    output logic          fifo_valid,
    output acc_pkg::cmd_t fifo_cmd,
    input  logic          fifo_pop,
    output logic          cmd_credit
);

    localparam int PW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CW = $clog2(FIFO_DEPTH + 1);

    acc_pkg::cmd_t  entries [FIFO_DEPTH];
    logic [PW-1:0]  wr_ptr;
    logic [PW-1:0]  rd_ptr;
    logic [CW-1:0]  count;

    function automatic logic [PW-1:0] next_ptr(input logic [PW-1:0] ptr);
        if (ptr == PW'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            entries[wr_ptr] <= cmd; // host holds a credit, so never full.
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end else begin
            if (cmd_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (fifo_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count      <= count + CW'(cmd_valid) - CW'(fifo_pop);
            cmd_credit <= fifo_pop; // one credit back per pop.
        end
    end

    assign fifo_valid = (count != '0);
    assign fifo_cmd   = entries[rd_ptr]; // show-ahead.

endmodule

// File: hw/core_array.sv
`timescale 1ns/100ps

module core_array #(
    parameter int NUM_CORES = 8
) (
    input  logic                        clk,
    input  logic                        init,
    input  acc_pkg::load_t              load,
    input  logic                        exec,
    input  logic [acc_pkg::ITEM_AW-1:0] exec_addr,
    input  logic                        update,
    input  logic                        shift,
    output logic [31:0]                 chain_out
);

    logic [31:0] acc_w [NUM_CORES];

    genvar g;
    generate
        for (g = 0; g < NUM_CORES; g++) begin : g_core
            logic        core_we;
            logic [31:0] core_next;

            assign core_we = load.we && (load.core == acc_pkg::CORE_W'(g));

            if (g == NUM_CORES - 1) begin : g_tail
                assign core_next = 32'h0; // chain end feeds zero.
            end else begin : g_link
                assign core_next = acc_w[g+1];
            end

            item_core u_core (
                .clk       (clk),
                .init      (init),
                .we        (core_we),
                .waddr     (load.addr),
                .wdata     (load.data),
                .exec      (exec),
                .exec_addr (exec_addr),
                .update    (update),
                .shift     (shift),
                .acc_next  (core_next),
                .acc       (acc_w[g])
            );
        end
    endgenerate

    assign chain_out = acc_w[0]; // core 0 leaves first.

endmodule

// File: hw/item_core.sv
`timescale 1ns/100ps

module item_core (
    input  logic                        clk,
    input  logic                        init,
    input  logic                        we,
    input  logic [acc_pkg::ITEM_AW-1:0] waddr,
    input  logic [31:0]                 wdata,
    input  logic                        exec,
    input  logic [acc_pkg::ITEM_AW-1:0] exec_addr,
    input  logic                        update,
    input  logic                        shift,
    input  logic [31:0]                 acc_next,
    output logic [31:0]                 acc
);

    logic [31:0]                 item_mem [0:(2**acc_pkg::ITEM_AW)-1];
    logic [acc_pkg::ITEM_AW-1:0] addr_q;
    logic                        exec_d1, exec_d2, exec_d3;
    logic                        init_d1, init_d2;
    logic [31:0]                 rd_q;
    logic [31:0]                 hold_q;
    logic [31:0]                 acc_sum;
    logic [31:0]                 acc_shift;

    always_ff @(posedge clk) begin
        if (we) begin
            item_mem[waddr] <= wdata;
        end
    end

    // ************************************************************
    // lookup and accumulate pipeline
    // ************************************************************

    always_ff @(posedge clk) begin
        exec_d1 <= exec;
        exec_d2 <= exec_d1;
        exec_d3 <= exec_d2;
        init_d1 <= init;
        init_d2 <= init_d1;
        if (exec) begin
            addr_q <= exec_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (exec_d1) begin
            rd_q <= item_mem[addr_q]; // memory read.
        end
        if (exec_d2) begin
            hold_q <= rd_q; // cuts the read to adder path.
        end
    end

    always_ff @(posedge clk) begin
        if (init_d2) begin
            acc_sum <= 32'h0; // clear beats a same-cycle add.
        end else if (exec_d3) begin
            acc_sum <= acc_sum + hold_q;
        end
    end

    // ************************************************************
    // output chain link
    // ************************************************************

    always_ff @(posedge clk) begin
        if (shift) begin
            acc_shift <= acc_next;
        end
    end

    assign acc = update ? acc_sum : acc_shift;

endmodule

// File: hw/acc_pkg.sv
package acc_pkg;

    // ************************************************************
    // widths
    // ************************************************************

    localparam int NUM_CORES_MAX = 16;
    localparam int CORE_W        = $clog2(NUM_CORES_MAX); // 4-bit core index.
    localparam int ITEM_AW       = 7;                     // 128 words per core.

    // ************************************************************
    // command, load and result words
    // ************************************************************

    typedef enum logic [1:0] {
        OP_INIT,
        OP_LOAD,
        OP_EXEC,
        OP_DRAIN
    } opcode_t;

    typedef struct packed {
        opcode_t             op;
        logic [CORE_W-1:0]   core;  // load target.
        logic [ITEM_AW-1:0]  addr;  // load or exec index.
        logic [31:0]         data;  // load word.
    } cmd_t;

    typedef struct packed {
        logic                we;
        logic [CORE_W-1:0]   core;
        logic [ITEM_AW-1:0]  addr;
        logic [31:0]         data;
    } load_t;

    typedef struct packed {
        logic                last;  // final value of a drain.
        logic [CORE_W-1:0]   core;
        logic [31:0]         sum;
    } result_t;

endpackage
